/* verilog/mouse_pkg.sv */
//////////////////////////////////////////////////
// PS/2 mouse shared types
// Byte, receiver and report structs, command codes
//////////////////////////////////////////////////

`default_nettype none

package mouse_pkg;

   // One PS/2 data byte
   typedef logic [7:0] ps2_byte_t;

   // Received frame with its error flag
   typedef struct packed {
      ps2_byte_t data;
      // Start, stop or parity fault
      logic      frame_error;
   } rx_byte_t;

   // Decoded movement report
   typedef struct packed {
      logic        button_l;
      logic        button_m;
      logic        button_r;
      logic        x_ovf;
      logic        y_ovf;
      // Sign-extended movement
      logic [11:0] x_move;
      logic [11:0] y_move;
   } mouse_report_t;

   //////////////////////////////////////////////////
   // Protocol bytes
   //////////////////////////////////////////////////

   // Read Data, the mouse answers with one packet
   localparam ps2_byte_t CMD_READ_DATA = 8'hEB;

   // Acknowledge sent ahead of every reply
   localparam ps2_byte_t RESP_ACK = 8'hFA;

endpackage

`default_nettype wire

/* verilog/ps2_line_filter.sv */
//////////////////////////////////////////////////
// PS/2 line filter
// Syncs both lines, debounces clock, flags falls
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ps2_line_filter #(
   parameter int FILTER_LEN = 8
) (
   input  logic clk,
   input  logic reset,
   input  logic ps2_clk_in,
   input  logic ps2_data_in,
   output logic clk_fall,
   output logic data_bit
);

   localparam int CNT_W = $clog2(FILTER_LEN + 1);

   // Two-stage synchronizers, idle lines are high
   logic [1:0]       clk_sync;
   logic [1:0]       data_sync;
   // Accepted clock level
   logic             clk_level;
   logic [CNT_W-1:0] stable_cnt;

   always_ff @(posedge clk) begin
      if (reset) begin
         clk_sync   <= 2'b11;
         data_sync  <= 2'b11;
         clk_level  <= 1'b1;
         stable_cnt <= '0;
         clk_fall   <= 1'b0;
      end else begin
         clk_sync  <= {clk_sync[0], ps2_clk_in};
         data_sync <= {data_sync[0], ps2_data_in};
         clk_fall  <= 1'b0;
         if (clk_sync[1] == clk_level) begin
            // Glitch or no change, start over
            stable_cnt <= '0;
         end else if (stable_cnt == CNT_W'(FILTER_LEN - 1)) begin
            clk_level  <= clk_sync[1];
            stable_cnt <= '0;
            // Only a high to low change is an edge
            clk_fall   <= clk_level;
         end else begin
            stable_cnt <= stable_cnt + 1'b1;
         end
      end
   end

   // Data settles while clock is high, no debounce needed
   assign data_bit = data_sync[1];

endmodule

`default_nettype wire

/* verilog/ps2_rx.sv */
//////////////////////////////////////////////////
// PS/2 receiver
// Shifts in 11-bit device frames, checks framing
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ps2_rx (
   input  logic                clk,
   input  logic                reset,
   input  logic                clk_fall,
   input  logic                data_bit,
   input  logic                rx_enable,
   output mouse_pkg::rx_byte_t rx_byte,
   output logic                rx_valid
);

   // Falling edges seen so far in this frame
   logic [3:0]  bit_cnt;
   // Start, data, parity, oldest bit at position 0
   logic [9:0]  shift_q;
   // Whole frame once the stop bit arrives
   logic [10:0] frame;
   logic        frame_bad;

   assign frame = {data_bit, shift_q};

   // Start must be 0, stop 1, data plus parity odd
   assign frame_bad = frame[0] | ~frame[10] | ~(^frame[9:1]);

   //////////////////////////////////////////////////
   // Bit counter
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         if (!rx_enable) begin
            // Disabled, drop any partial frame
            bit_cnt <= '0;
         end else if (clk_fall) begin
            if (bit_cnt == 4'd10) begin
               bit_cnt  <= '0;
               rx_valid <= 1'b1;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end
      end
   end

   // Shift register and output byte
   always_ff @(posedge clk) begin
      if (rx_enable && clk_fall) begin
         shift_q <= {data_bit, shift_q[9:1]};
         if (bit_cnt == 4'd10) begin
            // Data goes out even when framing failed
            rx_byte.data        <= frame[8:1];
            rx_byte.frame_error <= frame_bad;
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/ps2_tx.sv */
//////////////////////////////////////////////////
// PS/2 transmitter
// Sends one host-to-device command byte
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ps2_tx #(
   // Keep above FILTER_LEN plus sync delay so the
   // filter has seen our own clock pull first
   parameter int INHIBIT_CYCLES = 2500
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 clk_fall,
   input  logic                 data_bit,
   input  logic                 tx_start,
   input  mouse_pkg::ps2_byte_t tx_data,
   output logic                 tx_done,
   output logic                 tx_error,
   output logic                 ps2_clk_drive_low,
   output logic                 ps2_data_drive_low
);

   localparam int INH_W = $clog2(INHIBIT_CYCLES + 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_INHIBIT,
      ST_RTS,
      ST_SHIFT
   } state_t;

   state_t           state;
   logic [INH_W-1:0] inhibit_cnt;
   // Device clock edges in the shift phase
   logic [3:0]       edge_cnt;
   // Stop, parity and data, next bit at position 0
   logic [9:0]       tx_shift;

   // Host owns the clock only before request-to-send ends
   assign ps2_clk_drive_low = (state == ST_INHIBIT) || (state == ST_RTS);

   //////////////////////////////////////////////////
   // Control FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state              <= ST_IDLE;
         inhibit_cnt        <= '0;
         edge_cnt           <= '0;
         ps2_data_drive_low <= 1'b0;
         tx_done            <= 1'b0;
         tx_error           <= 1'b0;
      end else begin
         tx_done  <= 1'b0;
         tx_error <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (tx_start) begin
                  state       <= ST_INHIBIT;
                  inhibit_cnt <= '0;
               end
            end
            ST_INHIBIT: begin
               if (inhibit_cnt == INH_W'(INHIBIT_CYCLES - 1)) begin
                  // Start bit doubles as request-to-send
                  state              <= ST_RTS;
                  ps2_data_drive_low <= 1'b1;
               end else begin
                  inhibit_cnt <= inhibit_cnt + 1'b1;
               end
            end
            ST_RTS: begin
               // Release clock, device starts clocking
               state    <= ST_SHIFT;
               edge_cnt <= '0;
            end
            ST_SHIFT: begin
               if (clk_fall) begin
                  if (edge_cnt == 4'd10) begin
                     // Eleventh edge, device holds ack low
                     tx_done  <= 1'b1;
                     tx_error <= data_bit;
                     state    <= ST_IDLE;
                  end else begin
                     // Data bits, parity, then stop releases data
                     ps2_data_drive_low <= ~tx_shift[0];
                     edge_cnt           <= edge_cnt + 1'b1;
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Frame load and shift
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && tx_start) begin
         // Odd parity over data
         tx_shift <= {1'b1, ~^tx_data, tx_data};
      end else if (state == ST_SHIFT && clk_fall && edge_cnt != 4'd10) begin
         tx_shift <= {1'b1, tx_shift[9:1]};
      end
   end

endmodule

`default_nettype wire

/* verilog/mouse_poller.sv */
//////////////////////////////////////////////////
// Mouse poller
// Credit-gated Read Data polls, packet decode
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mouse_poller #(
   parameter int CREDITS       = 2,
   parameter int REPLY_TIMEOUT = 50000
) (
   input  logic                     clk,
   input  logic                     reset,
   input  mouse_pkg::rx_byte_t      rx_byte,
   input  logic                     rx_valid,
   input  logic                     tx_done,
   input  logic                     tx_error,
   input  logic                     report_credit,
   output logic                     tx_start,
   output mouse_pkg::ps2_byte_t     tx_data,
   output logic                     rx_enable,
   output mouse_pkg::mouse_report_t report,
   output logic                     report_valid
);

   localparam int CREDIT_W = $clog2(CREDITS + 1);
   localparam int TIMER_W  = $clog2(REPLY_TIMEOUT + 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SEND,
      ST_REPLY,
      // Bad byte seen, wait for the device to go quiet
      ST_FLUSH
   } state_t;

   state_t                   state;
   logic [CREDIT_W-1:0]      credit_count;
   // 0 ack, 1 status, 2 X, 3 Y
   logic [1:0]               byte_idx;
   logic [TIMER_W-1:0]       idle_timer;
   logic                     timer_expired;
   logic                     byte_bad;
   mouse_pkg::ps2_byte_t     status_q;
   mouse_pkg::ps2_byte_t     x_q;

   assign tx_data       = mouse_pkg::CMD_READ_DATA;
   assign rx_enable     = (state == ST_REPLY) || (state == ST_FLUSH);
   assign timer_expired = idle_timer == TIMER_W'(REPLY_TIMEOUT - 1);
   assign byte_bad      = rx_byte.frame_error ||
                          (byte_idx == 2'd0 && rx_byte.data != mouse_pkg::RESP_ACK);

   //////////////////////////////////////////////////
   // Credit counter
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         credit_count <= CREDIT_W'(CREDITS);
      end else if (report_credit && !report_valid) begin
         credit_count <= credit_count + 1'b1;
      end else if (report_valid && !report_credit) begin
         credit_count <= credit_count - 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Poll FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= ST_IDLE;
         tx_start     <= 1'b0;
         report_valid <= 1'b0;
         byte_idx     <= '0;
         idle_timer   <= '0;
      end else begin
         tx_start     <= 1'b0;
         report_valid <= 1'b0;
         case (state)
            ST_IDLE: begin
               // Credit spent by a report this cycle is not yet counted down
               if (credit_count != '0 && !report_valid) begin
                  state    <= ST_SEND;
                  tx_start <= 1'b1;
               end
            end
            ST_SEND: begin
               if (tx_done) begin
                  if (tx_error) begin
                     state <= ST_IDLE;
                  end else begin
                     state      <= ST_REPLY;
                     byte_idx   <= '0;
                     idle_timer <= '0;
                  end
               end
            end
            ST_REPLY: begin
               if (rx_valid) begin
                  idle_timer <= '0;
                  if (byte_bad) begin
                     state <= ST_FLUSH;
                  end else begin
                     byte_idx <= byte_idx + 1'b1;
                     if (byte_idx == 2'd3) begin
                        report_valid <= 1'b1;
                        state        <= ST_IDLE;
                     end
                  end
               end else if (timer_expired) begin
                  // Silent device, give up on this poll
                  state <= ST_IDLE;
               end else begin
                  idle_timer <= idle_timer + 1'b1;
               end
            end
            ST_FLUSH: begin
               // Rest of the packet is discarded
               if (rx_valid) begin
                  idle_timer <= '0;
               end else if (timer_expired) begin
                  state <= ST_IDLE;
               end else begin
                  idle_timer <= idle_timer + 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Byte capture and report decode
   always_ff @(posedge clk) begin
      if (state == ST_REPLY && rx_valid && !rx_byte.frame_error) begin
         case (byte_idx)
            2'd1: status_q <= rx_byte.data;
            2'd2: x_q      <= rx_byte.data;
            2'd3: begin
               // Status: yovf xovf ysgn xsgn 1 mid right left
               report.button_l <= status_q[0];
               report.button_r <= status_q[1];
               report.button_m <= status_q[2];
               report.x_ovf    <= status_q[6];
               report.y_ovf    <= status_q[7];
               // 9-bit two's complement widened to 12
               report.x_move   <= {{4{status_q[4]}}, x_q};
               report.y_move   <= {{4{status_q[5]}}, rx_byte.data};
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* verilog/ps2_mouse.sv */
//////////////////////////////////////////////////
// PS/2 mouse host controller
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ps2_mouse #(
   parameter int FILTER_LEN     = 8,
   parameter int INHIBIT_CYCLES = 2500,
   parameter int CREDITS        = 2,
   parameter int REPLY_TIMEOUT  = 50000
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     ps2_clk_in,
   input  logic                     ps2_data_in,
   input  logic                     report_credit,
   output logic                     ps2_clk_drive_low,
   output logic                     ps2_data_drive_low,
   output mouse_pkg::mouse_report_t report,
   output logic                     report_valid
);

   // Filtered line events
   logic                 clk_fall;
   logic                 data_bit;
   // Receiver to poller
   mouse_pkg::rx_byte_t  rx_byte;
   logic                 rx_valid;
   logic                 rx_enable;
   // Poller to transmitter and back
   mouse_pkg::ps2_byte_t tx_data;
   logic                 tx_start;
   logic                 tx_done;
   logic                 tx_error;

   ps2_line_filter #(
      .FILTER_LEN(FILTER_LEN)
   ) i_filter (
      .clk        (clk),
      .reset      (reset),
      .ps2_clk_in (ps2_clk_in),
      .ps2_data_in(ps2_data_in),
      .clk_fall   (clk_fall),
      .data_bit   (data_bit)
   );

   // Listens only, never drives the lines
   ps2_rx i_rx (
      .clk      (clk),
      .reset    (reset),
      .clk_fall (clk_fall),
      .data_bit (data_bit),
      .rx_enable(rx_enable),
      .rx_byte  (rx_byte),
      .rx_valid (rx_valid)
   );

   ps2_tx #(
      .INHIBIT_CYCLES(INHIBIT_CYCLES)
   ) i_tx (
      .clk               (clk),
      .reset             (reset),
      .clk_fall          (clk_fall),
      .data_bit          (data_bit),
      .tx_start          (tx_start),
      .tx_data           (tx_data),
      .tx_done           (tx_done),
      .tx_error          (tx_error),
      .ps2_clk_drive_low (ps2_clk_drive_low),
      .ps2_data_drive_low(ps2_data_drive_low)
   );

   mouse_poller #(
      .CREDITS      (CREDITS),
      .REPLY_TIMEOUT(REPLY_TIMEOUT)
   ) i_poller (
      .clk          (clk),
      .reset        (reset),
      .rx_byte      (rx_byte),
      .rx_valid     (rx_valid),
      .tx_done      (tx_done),
      .tx_error     (tx_error),
      .report_credit(report_credit),
      .tx_start     (tx_start),
      .tx_data      (tx_data),
      .rx_enable    (rx_enable),
      .report       (report),
      .report_valid (report_valid)
   );

endmodule

`default_nettype wire

/* testbench/ps2_mouse_assertions.sv */
//////////////////////////////////////////////////
// Poller checks on credits and report pulses
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ps2_mouse_assertions #(
   parameter int CREDITS  = 2,
   parameter int CREDIT_W = 2
) (
   input logic                clk,
   input logic                reset,
   input logic [CREDIT_W-1:0] credit_count,
   input logic                report_valid
);

   // Wrap below zero lands above CREDITS, so one bound covers both
   credit_in_range: assert property (
      @(posedge clk) disable iff (reset) credit_count <= CREDIT_W'(CREDITS)
   ) else $error("credit count out of range");

   // Report is a single-cycle pulse
   report_single_pulse: assert property (
      @(posedge clk) disable iff (reset) report_valid |=> !report_valid
   ) else $error("report_valid high two cycles in a row");

   report_needs_credit: assert property (
      @(posedge clk) disable iff (reset) report_valid |-> credit_count != '0
   ) else $error("report issued with no credit");

endmodule

bind mouse_poller ps2_mouse_assertions #(
   .CREDITS (CREDITS),
   .CREDIT_W(CREDIT_W)
) i_assertions (
   .clk         (clk),
   .reset       (reset),
   .credit_count(credit_count),
   .report_valid(report_valid)
);

`default_nettype wire

/* testbench/tb_ps2_mouse.sv */
//////////////////////////////////////////////////
// PS/2 mouse testbench
// Device model, credit driver, report checks
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_ps2_mouse;

   localparam int FILTER_LEN     = 2;
   localparam int INHIBIT_CYCLES = 20;
   localparam int CREDITS        = 2;
   localparam int REPLY_TIMEOUT  = 400;
   // Device clock half-period in clk cycles
   localparam int DEV_HALF       = 8;
   localparam int WAIT_LIMIT     = 10000;
   localparam int DRIVER_LIMIT   = 50000;
   localparam int MAX_CASES      = 32;
   localparam logic [31:0] SEED  = 32'h27ce5f87;

   logic clk;
   logic reset;
   logic report_credit;
   // Device side of the open-drain lines
   logic dev_clk;
   logic dev_data;
   logic ps2_clk_line;
   logic ps2_data_line;
   logic clk_drive_low;
   logic data_drive_low;
   mouse_pkg::mouse_report_t report;
   logic report_valid;

   logic [83:0]              cases_mem [0:MAX_CASES-1];
   mouse_pkg::mouse_report_t expected_q[$];
   int                       num_cases;
   int                       reports_seen;
   int                       credits_returned;

   // Wired-AND of device and host
   assign ps2_clk_line  = dev_clk & ~clk_drive_low;
   assign ps2_data_line = dev_data & ~data_drive_low;

   ps2_mouse #(
      .FILTER_LEN    (FILTER_LEN),
      .INHIBIT_CYCLES(INHIBIT_CYCLES),
      .CREDITS       (CREDITS),
      .REPLY_TIMEOUT (REPLY_TIMEOUT)
   ) i_dut (
      .clk               (clk),
      .reset             (reset),
      .ps2_clk_in        (ps2_clk_line),
      .ps2_data_in       (ps2_data_line),
      .report_credit     (report_credit),
      .ps2_clk_drive_low (clk_drive_low),
      .ps2_data_drive_low(data_drive_low),
      .report            (report),
      .report_valid      (report_valid)
   );

   always #20 clk = ~clk;

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
         $display("Finished with errors");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic report_failure(input string what);
      $display("Error at %0t ns: %s", $time, what);
      $display("Finished with errors");
      $fatal(1, "run aborted");
   endtask

   // Step n edges and land 1 ns past the last one
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   //////////////////////////////////////////////////
   // Device model
   //////////////////////////////////////////////////

   task automatic receive_command();
      int         waited;
      int         i;
      logic [9:0] bits;
      waited = 0;
      // Wait for request-to-send with data low and clock released
      while (!(data_drive_low && !clk_drive_low)) begin
         wait_cycles(1);
         waited++;
         if (waited > WAIT_LIMIT)
            report_failure("host never sent a request-to-send");
      end
      wait_cycles(DEV_HALF);
      // Data, parity and stop bits are read just before clock rises
      for (i = 0; i < 10; i++) begin
         dev_clk = 1'b0;
         wait_cycles(DEV_HALF);
         bits[i] = ps2_data_line;
         dev_clk = 1'b1;
         wait_cycles(DEV_HALF);
      end
      // Acknowledge bit
      dev_data = 1'b0;
      dev_clk  = 1'b0;
      wait_cycles(DEV_HALF);
      dev_clk  = 1'b1;
      wait_cycles(DEV_HALF);
      dev_data = 1'b1;
      check_value(32'(bits[7:0]), 32'(mouse_pkg::CMD_READ_DATA), "command byte");
      check_value(32'(^bits[8:0]), 32'd1, "command odd parity");
      check_value(32'(bits[9]), 32'd1, "command stop bit");
   endtask

   task automatic send_byte(input logic [7:0] value, input logic corrupt);
      logic [10:0] frame;
      int          i;
      frame = {1'b1, (~^value) ^ corrupt, value, 1'b0};
      for (i = 0; i < 11; i++) begin
         dev_data = frame[i];
         wait_cycles(DEV_HALF / 2);
         dev_clk = 1'b0;
         wait_cycles(DEV_HALF);
         dev_clk = 1'b1;
         wait_cycles(DEV_HALF / 2);
      end
      dev_data = 1'b1;
      wait_cycles(DEV_HALF);
   endtask

   //////////////////////////////////////////////////
   // Report monitor sampled mid-cycle
   //////////////////////////////////////////////////

   always @(negedge clk) begin
      if (!reset) begin
         if (report_valid) begin
            if (expected_q.size() == 0)
               report_failure("report arrived when none was expected");
            check_value(32'(report.button_l), 32'(expected_q[0].button_l), "button_l");
            check_value(32'(report.button_m), 32'(expected_q[0].button_m), "button_m");
            check_value(32'(report.button_r), 32'(expected_q[0].button_r), "button_r");
            check_value(32'(report.x_ovf), 32'(expected_q[0].x_ovf), "x_ovf");
            check_value(32'(report.y_ovf), 32'(expected_q[0].y_ovf), "y_ovf");
            check_value(32'(report.x_move), 32'(expected_q[0].x_move), "x_move");
            check_value(32'(report.y_move), 32'(expected_q[0].y_move), "y_move");
            void'(expected_q.pop_front());
            reports_seen++;
         end
         if (reports_seen > CREDITS + credits_returned)
            report_failure("more reports than credits allow");
         // Lines stay released with no credit left
         if (reports_seen - credits_returned == CREDITS) begin
            check_value(32'(clk_drive_low), 32'd0, "clock drive with zero credits");
            check_value(32'(data_drive_low), 32'd0, "data drive with zero credits");
         end
      end
   end

   // Credit return after a random hold-off
   initial begin : credit_driver
      int waited;
      int gap;
      void'($urandom(SEED));
      forever begin
         waited = 0;
         while (reports_seen <= credits_returned) begin
            wait_cycles(1);
            waited++;
            if (waited > DRIVER_LIMIT)
               report_failure("credit driver saw no report for too long");
         end
         gap = 500 + int'($urandom % 1500);
         wait_cycles(gap);
         report_credit = 1'b1;
         credits_returned++;
         wait_cycles(1);
         report_credit = 1'b0;
      end
   end

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      int          idx;
      int          waited;
      logic [83:0] line;
      mouse_pkg::mouse_report_t exp_rep;
      clk              = 1'b0;
      reset            = 1'b1;
      report_credit    = 1'b0;
      dev_clk          = 1'b1;
      dev_data         = 1'b1;
      reports_seen     = 0;
      credits_returned = 0;
      $readmemh("testbench/mouse_cases.txt", cases_mem);

      // Expected reports straight from the file columns
      num_cases = 0;
      while (num_cases < MAX_CASES && cases_mem[num_cases][3:0] != 4'hF) begin
         line = cases_mem[num_cases];
         if (line[3:0] == 4'h1) begin
            exp_rep.button_l = line[44];
            exp_rep.button_m = line[40];
            exp_rep.button_r = line[36];
            exp_rep.x_move   = line[35:24];
            exp_rep.y_move   = line[23:12];
            exp_rep.x_ovf    = line[8];
            exp_rep.y_ovf    = line[4];
            expected_q.push_back(exp_rep);
         end
         num_cases++;
      end

      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      check_value(32'(report_valid), 32'd0, "report_valid after reset");
      check_value(32'(clk_drive_low), 32'd0, "clock drive after reset");
      check_value(32'(data_drive_low), 32'd0, "data drive after reset");

      for (idx = 0; idx < num_cases; idx++) begin
         line = cases_mem[idx];
         receive_command();
         wait_cycles(2 * DEV_HALF);
         send_byte(line[83:76], 1'b0);
         send_byte(line[75:68], line[48]);
         send_byte(line[67:60], 1'b0);
         send_byte(line[59:52], 1'b0);
      end

      waited = 0;
      while (expected_q.size() != 0) begin
         wait_cycles(1);
         waited++;
         if (waited > WAIT_LIMIT)
            report_failure("expected reports never arrived");
      end
      wait_cycles(4);
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
verilog/mouse_pkg.sv
verilog/ps2_line_filter.sv
verilog/ps2_rx.sv
verilog/ps2_tx.sv
verilog/mouse_poller.sv
verilog/ps2_mouse.sv
testbench/ps2_mouse_assertions.sv
testbench/tb_ps2_mouse.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PS/2 mouse testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_ps2_mouse \
   --Mdir obj_dir -o tb_ps2_mouse \
   -f verilog.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/tb_ps2_mouse
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

exit 0

/* testbench/mouse_cases.txt */
// ack_status_x_y_corrupt_btnl_btnm_btnr_xmove_ymove_xovf_yovf_expect
// corrupt flips the status parity, expect F ends the list
FA_08_05_03_0_0_0_0_005_003_0_0_1
FA_09_10_20_0_1_0_0_010_020_0_0_1
FA_3A_FB_F0_0_0_0_1_FFB_FF0_0_0_1
FA_0C_00_7F_0_0_1_0_000_07F_0_0_1
FE_08_01_01_0_0_0_0_000_000_0_0_0
FA_1F_80_02_0_1_1_1_F80_002_0_0_1
FA_08_11_22_1_0_0_0_000_000_0_0_0
FA_CB_7F_80_0_1_0_1_07F_080_1_1_1
FA_2D_00_01_0_1_1_0_000_F01_0_0_1
FA_08_FF_FF_0_0_0_0_0FF_0FF_0_0_1
FF_FF_FF_FF_F_F_F_F_FFF_FFF_F_F_F
